/* rtl/vdp_bridge_pkg.sv */
// shared constants and types; fixed to the 858x525 ntsc 480p raster, no pal timing
`default_nettype none

package vdp_bridge_pkg;

    // ------------------------------
    // raster geometry
    // ------------------------------

    // columns per line, ntsc 480p
    localparam int h_total = 858;
    // lines per frame
    localparam int v_total = 525;
    // where the raster should sit when the vdp starts a frame
    localparam int start_x = 0;
    localparam int start_y = 480;

    // ------------------------------
    // widths
    // ------------------------------

    // vdp colour channel
    localparam int chan6_w = 6;
    // hdmi colour channel
    localparam int chan8_w = 8;
    // raster coordinate, covers 0..857
    localparam int coord_w = 10;
    // vdp coordinate as the core reports it
    localparam int vdp_coord_w = 11;

    typedef logic [chan6_w-1:0] chan6_t;
    typedef logic [chan8_w-1:0] chan8_t;
    typedef logic [coord_w-1:0] coord_t;
    typedef logic [vdp_coord_w-1:0] vdp_coord_t;
    // vdp port number from the mode pins
    typedef logic [1:0] port_sel_t;
    // host data byte
    typedef logic [7:0] byte_t;

    // ------------------------------
    // bundles
    // ------------------------------

    typedef struct packed {
        chan6_t r;
        chan6_t g;
        chan6_t b;
    } vdp_rgb_t;

    typedef struct packed {
        chan8_t r;
        chan8_t g;
        chan8_t b;
    } dvi_rgb_t;

    typedef struct packed {
        coord_t cx;
        coord_t cy;
    } raster_pos_t;

    typedef struct packed {
        vdp_coord_t cx;
        vdp_coord_t cy;
    } vdp_pos_t;

    // register access request towards the vdp, req is a one-cycle pulse
    typedef struct packed {
        logic      req;
        logic      wrt;
        port_sel_t adr;
        byte_t     dbo;
    } cpu_req_t;

    // host port states
    typedef enum logic {
        io_idle,
        io_held
    } io_state_t;

endpackage

`default_nettype wire

/* rtl/cpu_port_fsm.sv */
// strobes are sampled unsynchronized; one request per chip-select change, no back-pressure
`timescale 1ns/100ps
`default_nettype none

module cpu_port_fsm (
    input  logic                      clk_w,
    input  logic                      reset_n_w,
    input  logic                      csr_n,
    input  logic                      csw_n,
    input  vdp_bridge_pkg::port_sel_t mode,
    input  vdp_bridge_pkg::byte_t     cdo,
    output vdp_bridge_pkg::cpu_req_t  cpu_req
);

    vdp_bridge_pkg::io_state_t state;
    // chip-select pair seen when the last request was taken
    logic [1:0] cs_latch;
    // current pair, read strobe in the upper bit
    logic [1:0] cs_now;

    assign cs_now = {csr_n, csw_n};

    // ------------------------------
    // control path
    // ------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            state       <= vdp_bridge_pkg::io_idle;
            cs_latch    <= 2'b11;
            cpu_req.req <= 1'b0;
            cpu_req.wrt <= 1'b0;
            cpu_req.adr <= '0;
            cpu_req.dbo <= '0;
        end else begin
            case (state)
                vdp_bridge_pkg::io_idle: begin
                    // exactly one strobe low means a real access
                    cpu_req.req <= csr_n ^ csw_n;
                    cpu_req.wrt <= ~csw_n;
                    // payload taken with the request
                    cpu_req.adr <= mode;
                    cpu_req.dbo <= cdo;
                    cs_latch    <= cs_now;
                    state       <= vdp_bridge_pkg::io_held;
                end
                default: begin
                    // pulse ends here
                    cpu_req.req <= 1'b0;
                    cpu_req.wrt <= 1'b0;
                    // wait for the host to move the strobes
                    if (cs_latch != cs_now) begin
                        state <= vdp_bridge_pkg::io_idle;
                    end
                end
            endcase
        end
    end

    // a request never lasts longer than one clock
    req_single_cycle: assert property (
        @(posedge clk_w) disable iff (!reset_n_w)
        cpu_req.req |=> !cpu_req.req
    );

endmodule

`default_nettype wire

/* rtl/raster_counter.sv */
// ntsc 480p only; resync reloads the start point one clock after it is seen
`timescale 1ns/100ps
`default_nettype none

module raster_counter (
    input  logic                        clk_w,
    input  logic                        reset_n_w,
    input  logic                        resync,
    output vdp_bridge_pkg::raster_pos_t pos
);

    // last column and last line of the frame
    localparam vdp_bridge_pkg::coord_t last_x = vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::h_total - 1);
    localparam vdp_bridge_pkg::coord_t last_y = vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::v_total - 1);

    logic x_wrap;
    logic y_wrap;

    // end of line and end of frame
    assign x_wrap = (pos.cx == last_x);
    assign y_wrap = (pos.cy == last_y);

    // ------------------------------
    // column and row counters
    // ------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            pos.cx <= vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::start_x);
            pos.cy <= vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::start_y);
        end else if (resync) begin
            // jump to where the vdp expects us
            pos.cx <= vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::start_x);
            pos.cy <= vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::start_y);
        end else if (x_wrap) begin
            pos.cx <= '0;
            // row only moves on a line wrap
            if (y_wrap) begin
                pos.cy <= '0;
            end else begin
                pos.cy <= pos.cy + 1'b1;
            end
        end else begin
            pos.cx <= pos.cx + 1'b1;
        end
    end

    // position stays inside the frame
    pos_in_frame: assert property (
        @(posedge clk_w) disable iff (!reset_n_w)
        (pos.cx < vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::h_total)) &&
        (pos.cy < vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::v_total))
    );

endmodule

`default_nettype wire

/* rtl/frame_align_check.sv */
// checks alignment only at vdp (0,0); hdmi_reset also follows the async system reset
`timescale 1ns/100ps
`default_nettype none

module frame_align_check (
    input  logic                        clk_w,
    input  logic                        reset_n_w,
    input  vdp_bridge_pkg::vdp_pos_t    vdp_pos,
    input  logic                        vdp_hdmi_reset,
    input  vdp_bridge_pkg::raster_pos_t pos,
    output logic                        resync,
    output logic                        hdmi_reset
);

    logic vdp_frame_start;
    logic raster_at_start;
    logic misaligned;

    // vdp begins a new frame
    assign vdp_frame_start = (vdp_pos.cx == '0) && (vdp_pos.cy == '0);

    // raster sits at the expected start point
    assign raster_at_start =
        (pos.cx == vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::start_x)) &&
        (pos.cy == vdp_bridge_pkg::coord_t'(vdp_bridge_pkg::start_y));

    assign misaligned = vdp_frame_start && !raster_at_start;

    // ------------------------------
    // resync register
    // ------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            resync <= 1'b0;
        end else begin
            // vdp video reset passes through, a mismatch forces it
            resync <= vdp_hdmi_reset | misaligned;
        end
    end

    // encoder held in reset by either source
    assign hdmi_reset = resync | ~reset_n_w;

    // a missed frame start always triggers the reload
    misalign_resync: assert property (
        @(posedge clk_w) disable iff (!reset_n_w)
        misaligned |=> resync
    );

endmodule

`default_nettype wire

/* rtl/scanline_shader.sv */
// one register stage; darkening is a fixed halving on odd raster rows
`timescale 1ns/100ps
`default_nettype none

module scanline_shader (
    input  logic                        clk_w,
    input  logic                        reset_n_w,
    input  vdp_bridge_pkg::vdp_rgb_t    vdp_rgb,
    input  logic                        scanline_en,
    input  vdp_bridge_pkg::raster_pos_t pos,
    output vdp_bridge_pkg::dvi_rgb_t    dvi_rgb
);

    logic dark;

    // 6 to 8 bit widening, shifted down one bit when dark
    function automatic vdp_bridge_pkg::chan8_t widen(
        input vdp_bridge_pkg::chan6_t c,
        input logic                   dim
    );
        if (dim) begin
            return {1'b0, c, 1'b0};
        end
        return {c, 2'b00};
    endfunction

    // odd rows only
    assign dark = scanline_en && pos.cy[0];

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            dvi_rgb <= '0;
        end else begin
            dvi_rgb.r <= widen(vdp_rgb.r, dark);
            dvi_rgb.g <= widen(vdp_rgb.g, dark);
            dvi_rgb.b <= widen(vdp_rgb.b, dark);
        end
    end

endmodule

`default_nettype wire

/* rtl/vdp_video_bridge.sv */
// glue between vdp and hdmi encoder; request 2 clocks after strobe, colour 1 clock, pos live
`timescale 1ns/100ps
`default_nettype none

module vdp_video_bridge (
    input  logic                        clk_w,
    input  logic                        reset_n_w,
    // host port
    input  logic                        csr_n,
    input  logic                        csw_n,
    input  vdp_bridge_pkg::port_sel_t   mode,
    input  vdp_bridge_pkg::byte_t       cdo,
    // vdp video side
    input  vdp_bridge_pkg::vdp_rgb_t    vdp_rgb,
    input  logic                        scanline_en,
    input  vdp_bridge_pkg::vdp_pos_t    vdp_pos,
    input  logic                        vdp_hdmi_reset,
    // towards vdp core and encoder
    output vdp_bridge_pkg::cpu_req_t    cpu_req,
    output vdp_bridge_pkg::dvi_rgb_t    dvi_rgb,
    output vdp_bridge_pkg::raster_pos_t pos,
    output logic                        hdmi_reset
);

    // reload request from the alignment check to the raster timer
    logic resync;

    // ------------------------------
    // host port
    // ------------------------------
    cpu_port_fsm cpu_port_fsm_inst (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .csr_n     (csr_n),
        .csw_n     (csw_n),
        .mode      (mode),
        .cdo       (cdo),
        .cpu_req   (cpu_req)
    );

    // raster timer
    raster_counter raster_counter_inst (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .resync    (resync),
        .pos       (pos)
    );

    // frame start vs raster
    frame_align_check frame_align_check_inst (
        .clk_w          (clk_w),
        .reset_n_w      (reset_n_w),
        .vdp_pos        (vdp_pos),
        .vdp_hdmi_reset (vdp_hdmi_reset),
        .pos            (pos),
        .resync         (resync),
        .hdmi_reset     (hdmi_reset)
    );

    // colour path
    scanline_shader scanline_shader_inst (
        .clk_w       (clk_w),
        .reset_n_w   (reset_n_w),
        .vdp_rgb     (vdp_rgb),
        .scanline_en (scanline_en),
        .pos         (pos),
        .dvi_rgb     (dvi_rgb)
    );

endmodule

`default_nettype wire

/* test/tb_vdp_video_bridge.sv */
// run from the project root; each trace step drives on a rising edge, checks on a falling edge
`timescale 1ns/100ps
`default_nettype none

module tb_vdp_video_bridge;

    localparam string trace_path = "test/bridge_trace.txt";
    localparam int max_steps = 64;
    localparam int reset_cycles = 5;
    // slack on top of the summed trace waits
    localparam int timeout_margin = 200;
    // raster index of the expected frame start, and frame length
    localparam int start_idx = vdp_bridge_pkg::start_y * vdp_bridge_pkg::h_total +
                               vdp_bridge_pkg::start_x;
    localparam int frame_len = vdp_bridge_pkg::h_total * vdp_bridge_pkg::v_total;
    // marks a position column that the model supplies
    localparam vdp_bridge_pkg::coord_t pos_from_model = 10'h3ff;

    // one trace record
    typedef struct packed {
        int                          test_id;
        logic                        csr_n;
        logic                        csw_n;
        vdp_bridge_pkg::port_sel_t   mode;
        vdp_bridge_pkg::byte_t       cdo;
        vdp_bridge_pkg::vdp_rgb_t    rgb;
        logic                        scanline_en;
        vdp_bridge_pkg::vdp_pos_t    vdp_pos;
        logic                        vdp_hdmi_reset;
        int                          wait_cycles;
        vdp_bridge_pkg::cpu_req_t    exp_req;
        vdp_bridge_pkg::dvi_rgb_t    exp_rgb;
        logic                        exp_hdmi_reset;
        vdp_bridge_pkg::raster_pos_t exp_pos;
    } step_t;

    logic                        clk_w = 1'b0;
    logic                        reset_n_w;
    logic                        csr_n;
    logic                        csw_n;
    vdp_bridge_pkg::port_sel_t   mode;
    vdp_bridge_pkg::byte_t       cdo;
    vdp_bridge_pkg::vdp_rgb_t    vdp_rgb;
    logic                        scanline_en;
    vdp_bridge_pkg::vdp_pos_t    vdp_pos;
    logic                        vdp_hdmi_reset;
    vdp_bridge_pkg::cpu_req_t    cpu_req;
    vdp_bridge_pkg::dvi_rgb_t    dvi_rgb;
    vdp_bridge_pkg::raster_pos_t pos;
    logic                        hdmi_reset;

    step_t steps [max_steps];
    int    step_count = 0;
    int    step_idx;
    int    test_errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    // reference raster as a linear index into the frame
    int                          model_idx;
    logic                        model_resync;
    vdp_bridge_pkg::raster_pos_t model_pos;

    vdp_video_bridge vdp_video_bridge_inst (
        .clk_w          (clk_w),
        .reset_n_w      (reset_n_w),
        .csr_n          (csr_n),
        .csw_n          (csw_n),
        .mode           (mode),
        .cdo            (cdo),
        .vdp_rgb        (vdp_rgb),
        .scanline_en    (scanline_en),
        .vdp_pos        (vdp_pos),
        .vdp_hdmi_reset (vdp_hdmi_reset),
        .cpu_req        (cpu_req),
        .dvi_rgb        (dvi_rgb),
        .pos            (pos),
        .hdmi_reset     (hdmi_reset)
    );

    // 100 ns clock
    always #50 clk_w = ~clk_w;

    // ------------------------------
    // reference raster model
    // ------------------------------
    assign model_pos.cx = vdp_bridge_pkg::coord_t'(model_idx % vdp_bridge_pkg::h_total);
    assign model_pos.cy = vdp_bridge_pkg::coord_t'(model_idx / vdp_bridge_pkg::h_total);

    always @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            model_idx    <= start_idx;
            model_resync <= 1'b0;
        end else begin
            // video reset, or a vdp frame start away from the start point
            model_resync <= vdp_hdmi_reset ||
                ((vdp_pos.cx == '0) && (vdp_pos.cy == '0) && (model_idx != start_idx));
            if (model_resync) begin
                model_idx <= start_idx;
            end else begin
                model_idx <= (model_idx + 1) % frame_len;
            end
        end
    end

    // run limit from the trace length
    always @(posedge clk_w) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: trace not finished after %0d cycles", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // ------------------------------
    // trace reader
    // ------------------------------
    task automatic load_trace();
        int               fd;
        int               total;
        logic [8*200-1:0] line_buf;
        logic [31:0]      f [18];
        step_t            s;
        total = 0;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %s", trace_path);
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                // comment lines do not scan as a record
                if ($sscanf(line_buf, "%d %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]) == 18 &&
                        step_count < max_steps) begin
                    s.test_id        = int'(f[0]);
                    s.csr_n          = f[1][0];
                    s.csw_n          = f[2][0];
                    s.mode           = vdp_bridge_pkg::port_sel_t'(f[3]);
                    s.cdo            = vdp_bridge_pkg::byte_t'(f[4]);
                    s.rgb.r          = vdp_bridge_pkg::chan6_t'(f[5]);
                    s.rgb.g          = vdp_bridge_pkg::chan6_t'(f[6]);
                    s.rgb.b          = vdp_bridge_pkg::chan6_t'(f[7]);
                    s.scanline_en    = f[8][0];
                    s.vdp_pos.cx     = vdp_bridge_pkg::vdp_coord_t'(f[9]);
                    s.vdp_pos.cy     = vdp_bridge_pkg::vdp_coord_t'(f[10]);
                    s.vdp_hdmi_reset = f[11][0];
                    s.wait_cycles    = int'(f[12]);
                    s.exp_req        = vdp_bridge_pkg::cpu_req_t'(f[13]);
                    s.exp_rgb        = vdp_bridge_pkg::dvi_rgb_t'(f[14]);
                    s.exp_hdmi_reset = f[15][0];
                    s.exp_pos.cx     = vdp_bridge_pkg::coord_t'(f[16]);
                    s.exp_pos.cy     = vdp_bridge_pkg::coord_t'(f[17]);
                    steps[step_count] = s;
                    total += s.wait_cycles + 1;
                    step_count++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = reset_cycles + total + timeout_margin;
    endtask

    // ------------------------------
    // drive and check
    // ------------------------------
    task automatic apply_inputs(input step_t s);
        csr_n          <= s.csr_n;
        csw_n          <= s.csw_n;
        mode           <= s.mode;
        cdo            <= s.cdo;
        vdp_rgb        <= s.rgb;
        scanline_en    <= s.scanline_en;
        vdp_pos        <= s.vdp_pos;
        vdp_hdmi_reset <= s.vdp_hdmi_reset;
    endtask

    // between checkpoints the host port must stay quiet
    task automatic expect_no_pulse(input int id);
        if (cpu_req.req !== 1'b0) begin
            $display("Mismatch cpu_req.req: got %h expected %h (test %0d)",
                     cpu_req.req, 1'b0, id);
            test_errors++;
        end
    endtask

    task automatic check_outputs(input step_t s);
        if (cpu_req !== s.exp_req) begin
            $display("Mismatch cpu_req: got %h expected %h (test %0d)",
                     cpu_req, s.exp_req, s.test_id);
            test_errors++;
        end
        if (dvi_rgb !== s.exp_rgb) begin
            $display("Mismatch dvi_rgb: got %h expected %h (test %0d)",
                     dvi_rgb, s.exp_rgb, s.test_id);
            test_errors++;
        end
        if (hdmi_reset !== s.exp_hdmi_reset) begin
            $display("Mismatch hdmi_reset: got %h expected %h (test %0d)",
                     hdmi_reset, s.exp_hdmi_reset, s.test_id);
            test_errors++;
        end
        if (pos !== model_pos) begin
            $display("Mismatch pos: got %h expected %h (test %0d)", pos, model_pos, s.test_id);
            test_errors++;
        end
        // trace may also pin the position outright
        if (s.exp_pos.cx != pos_from_model && pos !== s.exp_pos) begin
            $display("Mismatch pos: got %h expected %h (test %0d)", pos, s.exp_pos, s.test_id);
            test_errors++;
        end
    endtask

    task automatic close_test(input int id);
        if (test_errors == 0) begin
            $display("test %0d finished: ok", id);
            tests_passed++;
        end else begin
            $display("test %0d finished: %0d errors", id, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        reset_n_w      = 1'b0;
        csr_n          = 1'b1;
        csw_n          = 1'b1;
        mode           = '0;
        cdo            = '0;
        vdp_rgb        = '0;
        scanline_en    = 1'b0;
        // anywhere but the vdp frame start
        vdp_pos.cx     = 11'h010;
        vdp_pos.cy     = 11'h010;
        vdp_hdmi_reset = 1'b0;
        load_trace();
        repeat (reset_cycles - 1) @(posedge clk_w);
        // encoder reset follows the system reset
        @(negedge clk_w);
        if (hdmi_reset !== 1'b1) begin
            $display("Mismatch hdmi_reset: got %h expected %h during reset", hdmi_reset, 1'b1);
            test_errors++;
        end
        close_test(0);
        @(posedge clk_w);
        reset_n_w <= 1'b1;
        for (step_idx = 0; step_idx < step_count; step_idx++) begin
            apply_inputs(steps[step_idx]);
            // every cycle before the checkpoint is free of requests
            repeat (steps[step_idx].wait_cycles) begin
                @(negedge clk_w);
                expect_no_pulse(steps[step_idx].test_id);
                @(posedge clk_w);
            end
            @(negedge clk_w);
            check_outputs(steps[step_idx]);
            // last record of a test closes it
            if (step_idx == step_count - 1 ||
                    steps[step_idx + 1].test_id != steps[step_idx].test_id) begin
                close_test(steps[step_idx].test_id);
            end
            @(posedge clk_w);
        end
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && step_count > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/bridge_trace.txt */
# test csr_n csw_n mode cdo r g b scanline_en vdp_cx vdp_cy vdp_hdmi_reset wait(dec)
# then expected cpu_req dvi_rgb hdmi_reset pos_cx pos_cy (3FF 3FF takes pos from the model)
# test 1 write strobe, pulse two cycles after csw_n falls
1 1 1 1 A5 00 00 00 0 010 010 0 0 000 000000 0 000 1E0
1 1 0 1 A5 00 00 00 0 010 010 0 1 1A5 000000 0 3FF 3FF
1 1 0 1 A5 00 00 00 0 010 010 0 0 DA5 000000 0 3FF 3FF
1 1 0 1 A5 00 00 00 0 010 010 0 3 1A5 000000 0 3FF 3FF
1 1 1 2 3C 00 00 00 0 010 010 0 3 23C 000000 0 3FF 3FF
1 1 0 2 3C 00 00 00 0 010 010 0 2 E3C 000000 0 3FF 3FF
1 1 1 2 3C 00 00 00 0 010 010 0 3 23C 000000 0 3FF 3FF
# test 2 read strobe, no pulse on release
2 0 1 3 5A 00 00 00 0 010 010 0 2 B5A 000000 0 3FF 3FF
2 1 1 3 5A 00 00 00 0 010 010 0 3 35A 000000 0 3FF 3FF
# test 3 raster, line wrap then frame wrap
3 1 1 3 5A 00 00 00 0 010 010 0 831 35A 000000 0 359 1E0
3 1 1 3 5A 00 00 00 0 010 010 0 0 35A 000000 0 000 1E1
3 1 1 3 5A 00 00 00 0 010 010 0 37750 35A 000000 0 359 20C
3 1 1 3 5A 00 00 00 0 010 010 0 0 35A 000000 0 000 000
# test 4 shading off, on in row 0, on in row 1, off in row 1
4 1 1 3 5A 3F 15 2A 0 010 010 0 1 35A FC54A8 0 3FF 3FF
4 1 1 3 5A 01 20 0F 1 010 010 0 1 35A 04803C 0 3FF 3FF
4 1 1 3 5A 3F 15 2A 1 010 010 0 854 35A 7E2A54 0 001 001
4 1 1 3 5A 3F 15 2A 0 010 010 0 1 35A FC54A8 0 3FF 3FF
# test 5 misaligned start, reload, video reset, aligned start
5 1 1 3 5A 3F 15 2A 0 000 000 0 1 35A FC54A8 1 005 001
5 1 1 3 5A 3F 15 2A 0 010 010 0 0 35A FC54A8 1 000 1E0
5 1 1 3 5A 3F 15 2A 0 010 010 0 1 35A FC54A8 0 001 1E0
5 1 1 3 5A 3F 15 2A 0 010 010 1 1 35A FC54A8 1 003 1E0
5 1 1 3 5A 3F 15 2A 0 000 000 0 1 35A FC54A8 0 000 1E0
5 1 1 3 5A 3F 15 2A 0 010 010 0 1 35A FC54A8 0 002 1E0

/* vlog.f */
rtl/vdp_bridge_pkg.sv
rtl/cpu_port_fsm.sv
rtl/raster_counter.sv
rtl/frame_align_check.sv
rtl/scanline_shader.sv
rtl/vdp_video_bridge.sv
test/tb_vdp_video_bridge.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_vdp_video_bridge -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
